// ==== common/decode_consts.svh ====
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// Instruction word as delivered by the memory stage.
// Bits 34:32 are side-band flags, bits 31:0 the ARM encoding.
`define DEC_INSTR_W     35

// Thumb state bit in the CPSR.
`define DEC_CPSR_T      5

// Low 28 bits of SUB LR, PC, #4 (ARM state).
`define DEC_LINK_ARM    28'h24FE004
// Low 28 bits of SUB LR, PC, #2 (Thumb state).
`define DEC_LINK_THUMB  28'h24FE002

// Link bit of a branch.
`define DEC_BL_BIT      24
// Opcode in bits 27:25 for B and BL.
`define DEC_BR_OP       3'b101

// Field positions, each field 4 bits wide.
`define DEC_COND_LSB    28
`define DEC_RN_LSB      16
`define DEC_RD_LSB      12
`define DEC_FIELD_W     4

`endif

// ==== common/decode_pkg.sv ====
package decode_pkg;

        // BL expander states.
        // Idle passes instructions through.
        // Link state emits the held branch without its link bit.
        typedef enum logic
        {
                BL_IDLE = 1'b0,
                BL_LINK = 1'b1
        } bl_state_t;

        // Coarse instruction class handed to issue.
        // Decoded from bits 27:24 only.
        typedef enum logic [2:0]
        {
                // 00xx covers ALU ops and PSR moves.
                CLS_DATA_PROC  = 3'd0,
                // 01xx covers single loads and stores.
                CLS_LOAD_STORE = 3'd1,
                // 101x covers B and BL.
                CLS_BRANCH     = 3'd2,
                // 1111 is a software interrupt.
                CLS_SWI        = 3'd3,
                // Everything else for now.
                CLS_UNDEF      = 3'd4
        } instr_class_t;

        // Block transfers and coprocessor ops fall into CLS_UNDEF
        // until the rest of the decoder is brought in.

endpackage

// ==== common/instr_if.sv ====
`include "decode_consts.svh"

// One instruction in flight between decode stages.
// Interrupt levels ride along so they stay with their instruction.
interface instr_if;

        // Instruction word with flags included.
        logic [`DEC_INSTR_W-1:0]        instr;
        // Qualifies instr.
        logic                           valid;
        // IRQ level sampled with this instruction.
        logic                           irq;
        // FIQ level sampled with this instruction.
        logic                           fiq;

        // Producing stage.
        modport src
        (
                output instr,
                output valid,
                output irq,
                output fiq
        );

        // Consuming stage.
        modport dst
        (
                input  instr,
                input  valid,
                input  irq,
                input  fiq
        );

endinterface

// ==== src/fetch_latch.sv ====
`include "decode_consts.svh"

module fetch_latch
(
        input  logic                            i_clk,
        input  logic                            i_reset,

        // Flush from later stages.
        input  logic                            i_clear,
        // Expander or issue not ready.
        input  logic                            i_hold,

        // From the memory stage.
        input  logic [`DEC_INSTR_W-1:0]         i_instruction,
        input  logic                            i_instruction_valid,
        input  logic                            i_irq,
        input  logic                            i_fiq,

        // To the BL expander.
        instr_if.src                            o_bus
);

        logic [`DEC_INSTR_W-1:0]        instr_ff;
        logic                           valid_ff;
        logic                           irq_ff;
        logic                           fiq_ff;

        // Control part.
        // Clear wins over hold so a flush is never delayed.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        valid_ff <= 1'b0;
                        irq_ff   <= 1'b0;
                        fiq_ff   <= 1'b0;
                end
                else if (i_clear)
                begin
                        valid_ff <= 1'b0;
                        irq_ff   <= 1'b0;
                        fiq_ff   <= 1'b0;
                end
                else if (!i_hold)
                begin
                        valid_ff <= i_instruction_valid;
                        // Sampled with the word, not later.
                        irq_ff   <= i_irq;
                        fiq_ff   <= i_fiq;
                end
        end

        // Instruction word.
        // Only meaningful while valid_ff is set.
        always_ff @(posedge i_clk)
        begin
                if (!i_hold)
                begin
                        instr_ff <= i_instruction;
                end
        end

        // Held copy drives the expander.
        assign o_bus.instr = instr_ff;
        assign o_bus.valid = valid_ff;
        assign o_bus.irq   = irq_ff;
        assign o_bus.fiq   = fiq_ff;

endmodule

// ==== bl_expand/bl_expand_fsm.sv ====
`include "decode_consts.svh"

module bl_expand_fsm
(
        input  logic                    i_clk,
        input  logic                    i_reset,

        // Flush from later stages.
        input  logic                    i_clear,
        // Issue not ready freezes the state.
        input  logic                    i_stall_from_issue,

        // Current CPSR. Only T is looked at.
        input  logic [31:0]             i_cpsr,

        // From the input latch.
        instr_if.dst                    i_bus,
        // To the output stage.
        instr_if.src                    o_bus,

        // Keeps the latch holding the BL for a second cycle.
        output logic                    o_stall
);

        import decode_pkg::*;

        bl_state_t                      state_ff;
        bl_state_t                      state_nxt;

        // Current word is a BL.
        logic                           is_bl;

        // Crafted link write whose PC offset follows the T bit.
        logic [27:0]                    link_low;

        assign is_bl = (i_bus.instr[27:25] == `DEC_BR_OP) && i_bus.instr[`DEC_BL_BIT];

        // PC reads 8 ahead in ARM, 4 ahead in Thumb.
        assign link_low = i_cpsr[`DEC_CPSR_T] ? `DEC_LINK_THUMB : `DEC_LINK_ARM;

        always_comb
        begin
                // Default is a plain pass-through.
                o_bus.instr = i_bus.instr;
                o_bus.valid = i_bus.valid;
                o_bus.irq   = i_bus.irq;
                o_bus.fiq   = i_bus.fiq;
                o_stall     = 1'b0;
                state_nxt   = BL_IDLE;

                if (i_bus.valid)
                begin
                        case (state_ff)
                        BL_IDLE:
                        begin
                                if (is_bl)
                                begin
                                        // First half is SUB LR, PC, #imm.
                                        // Flags and condition kept from the BL.
                                        o_bus.instr = {i_bus.instr[`DEC_INSTR_W-1:28], link_low};
                                        // Fetch must not move on yet.
                                        o_stall     = 1'b1;
                                        // No interrupt between the two halves.
                                        o_bus.irq   = 1'b0;
                                        o_bus.fiq   = 1'b0;
                                        state_nxt   = BL_LINK;
                                end
                        end

                        BL_LINK:
                        begin
                                // Second half is the same branch with L cleared.
                                o_bus.instr[`DEC_BL_BIT] = 1'b0;
                                // Still masked.
                                o_bus.irq   = 1'b0;
                                o_bus.fiq   = 1'b0;
                                state_nxt   = BL_IDLE;
                        end

                        default:
                        begin
                                state_nxt   = BL_IDLE;
                        end
                        endcase
                end
        end

        // State only moves when issue takes the current output.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        state_ff <= BL_IDLE;
                end
                else if (i_clear)
                begin
                        state_ff <= BL_IDLE;
                end
                else if (!i_stall_from_issue)
                begin
                        state_ff <= state_nxt;
                end
        end

        // Entry into BL_LINK needs a valid BL on the cycle before.
        a_link_from_bl : assert property (
                @(posedge i_clk) disable iff (i_reset)
                (state_ff == BL_LINK && $past(state_ff) == BL_IDLE)
                        |-> $past(i_bus.valid && is_bl)
        ) else $error("BL_LINK entered without a valid BL");

        // Second half must let fetch go again.
        // The latch still holds the BL it came from.
        a_no_stall_in_link : assert property (
                @(posedge i_clk) disable iff (i_reset)
                (state_ff == BL_LINK) |-> (!o_stall && i_bus.valid && is_bl)
        ) else $error("Fetch stalled in BL_LINK or the BL was not held");

endmodule

// ==== src/decode_output_stage.sv ====
`include "decode_consts.svh"

module decode_output_stage
(
        input  logic                            i_clk,
        input  logic                            i_reset,

        // Flush from later stages.
        input  logic                            i_clear,
        // Issue not ready holds everything.
        input  logic                            i_stall_from_issue,

        // From the BL expander.
        instr_if.dst                            i_bus,

        // To issue.
        output logic                            o_valid,
        output logic [`DEC_INSTR_W-1:0]         o_instruction,
        output decode_pkg::instr_class_t        o_class,
        output logic [`DEC_FIELD_W-1:0]         o_cond,
        output logic [`DEC_FIELD_W-1:0]         o_rd,
        output logic [`DEC_FIELD_W-1:0]         o_rn,
        output logic                            o_irq,
        output logic                            o_fiq
);

        import decode_pkg::*;

        // Class of the incoming word.
        instr_class_t                   cls_nxt;

        // Coarse decode on bits 27:24.
        always_comb
        begin
                casez (i_bus.instr[27:24])
                4'b00??:
                        cls_nxt = CLS_DATA_PROC;
                4'b01??:
                        cls_nxt = CLS_LOAD_STORE;
                4'b101?:
                        cls_nxt = CLS_BRANCH;
                4'b1111:
                        cls_nxt = CLS_SWI;
                default:
                        cls_nxt = CLS_UNDEF;
                endcase
        end

        // Valid and interrupts.
        // Clear takes priority over a stall.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_valid <= 1'b0;
                        o_irq   <= 1'b0;
                        o_fiq   <= 1'b0;
                end
                else if (i_clear)
                begin
                        o_valid <= 1'b0;
                        o_irq   <= 1'b0;
                        o_fiq   <= 1'b0;
                end
                else if (!i_stall_from_issue)
                begin
                        o_valid <= i_bus.valid;
                        o_irq   <= i_bus.irq;
                        o_fiq   <= i_bus.fiq;
                end
        end

        // Payload is qualified by o_valid downstream.
        always_ff @(posedge i_clk)
        begin
                if (!i_stall_from_issue)
                begin
                        o_instruction <= i_bus.instr;
                        o_class       <= cls_nxt;
                        o_cond        <= i_bus.instr[`DEC_COND_LSB +: `DEC_FIELD_W];
                        o_rn          <= i_bus.instr[`DEC_RN_LSB +: `DEC_FIELD_W];
                        o_rd          <= i_bus.instr[`DEC_RD_LSB +: `DEC_FIELD_W];
                end
        end

        // Issue sees a frozen output while it stalls.
        // The waiting input must still be there afterwards.
        a_hold_on_stall : assert property (
                @(posedge i_clk) disable iff (i_reset)
                (i_stall_from_issue && !i_clear)
                        |=> ($stable(o_valid) && $stable(o_instruction)
                             && $stable(i_bus.valid))
        ) else $error("Decode output or its input changed under issue stall");

endmodule

// ==== src/decode_front.sv ====
`include "decode_consts.svh"

module decode_front
(
        input  logic                            i_clk,
        input  logic                            i_reset,

        // Memory stage.
        input  logic [`DEC_INSTR_W-1:0]         i_instruction,
        input  logic                            i_instruction_valid,
        input  logic                            i_irq,
        input  logic                            i_fiq,

        // Control.
        input  logic [31:0]                     i_cpsr,
        input  logic                            i_clear,
        input  logic                            i_stall_from_issue,

        // Fetch.
        output logic                            o_stall_to_fetch,

        // Issue.
        output logic                            o_valid,
        output logic [`DEC_INSTR_W-1:0]         o_instruction,
        output decode_pkg::instr_class_t        o_class,
        output logic [`DEC_FIELD_W-1:0]         o_cond,
        output logic [`DEC_FIELD_W-1:0]         o_rd,
        output logic [`DEC_FIELD_W-1:0]         o_rn,
        output logic                            o_irq,
        output logic                            o_fiq
);

        // Latch to expander.
        instr_if                lat_bus ();
        // Expander to output stage.
        instr_if                exp_bus ();

        // Expander wants the BL held for its second half.
        logic                   bl_stall;

        // Same level stops fetch and freezes the latch.
        assign o_stall_to_fetch = bl_stall | i_stall_from_issue;

        fetch_latch u_fetch_latch
        (
                .i_clk                  (i_clk),
                .i_reset                (i_reset),
                .i_clear                (i_clear),
                .i_hold                 (o_stall_to_fetch),
                .i_instruction          (i_instruction),
                .i_instruction_valid    (i_instruction_valid),
                .i_irq                  (i_irq),
                .i_fiq                  (i_fiq),
                .o_bus                  (lat_bus.src)
        );

        bl_expand_fsm u_bl_expand_fsm
        (
                .i_clk                  (i_clk),
                .i_reset                (i_reset),
                .i_clear                (i_clear),
                .i_stall_from_issue     (i_stall_from_issue),
                .i_cpsr                 (i_cpsr),
                .i_bus                  (lat_bus.dst),
                .o_bus                  (exp_bus.src),
                .o_stall                (bl_stall)
        );

        decode_output_stage u_decode_output_stage
        (
                .i_clk                  (i_clk),
                .i_reset                (i_reset),
                .i_clear                (i_clear),
                .i_stall_from_issue     (i_stall_from_issue),
                .i_bus                  (exp_bus.dst),
                .o_valid                (o_valid),
                .o_instruction          (o_instruction),
                .o_class                (o_class),
                .o_cond                 (o_cond),
                .o_rd                   (o_rd),
                .o_rn                   (o_rn),
                .o_irq                  (o_irq),
                .o_fiq                  (o_fiq)
        );

endmodule

// ==== testbench/tb_decode_front.sv ====
`include "decode_consts.svh"

module tb_decode_front;

        import decode_pkg::*;

        // Run length and watchdog limits in cycles.
        localparam int RUN_CYCLES  = 3000;
        localparam int DRAIN_LIMIT = 200;
        localparam int IDLE_LIMIT  = 200;

        // One expected output item.
        typedef struct packed
        {
                logic [`DEC_INSTR_W-1:0]        instr;
                instr_class_t                   cls;
                logic [3:0]                     cond;
                logic [3:0]                     rd;
                logic [3:0]                     rn;
                logic                           irq;
                logic                           fiq;
        } exp_entry_t;

        logic                           i_clk;
        logic                           i_reset;
        logic [`DEC_INSTR_W-1:0]        i_instruction;
        logic                           i_instruction_valid;
        logic                           i_irq;
        logic                           i_fiq;
        logic [31:0]                    i_cpsr;
        logic                           i_clear;
        logic                           i_stall_from_issue;
        logic                           o_stall_to_fetch;
        logic                           o_valid;
        logic [`DEC_INSTR_W-1:0]        o_instruction;
        instr_class_t                   o_class;
        logic [3:0]                     o_cond;
        logic [3:0]                     o_rd;
        logic [3:0]                     o_rn;
        logic                           o_irq;
        logic                           o_fiq;

        // Model state.
        exp_entry_t                     exp_q[$];
        logic [31:0]                    rng_state;
        // A BL sits in the latch and its link half is not yet out.
        logic                           bl_pending;
        logic                           seen_accept;
        int                             error_count;
        int                             idle_cycles;
        int                             drain_cycles;
        int                             checked_count;

        decode_front u_decode_front
        (
                .i_clk                  (i_clk),
                .i_reset                (i_reset),
                .i_instruction          (i_instruction),
                .i_instruction_valid    (i_instruction_valid),
                .i_irq                  (i_irq),
                .i_fiq                  (i_fiq),
                .i_cpsr                 (i_cpsr),
                .i_clear                (i_clear),
                .i_stall_from_issue     (i_stall_from_issue),
                .o_stall_to_fetch       (o_stall_to_fetch),
                .o_valid                (o_valid),
                .o_instruction          (o_instruction),
                .o_class                (o_class),
                .o_cond                 (o_cond),
                .o_rd                   (o_rd),
                .o_rn                   (o_rn),
                .o_irq                  (o_irq),
                .o_fiq                  (o_fiq)
        );

        // Period 20.
        always #10 i_clk = ~i_clk;

        function automatic logic [31:0] xorshift32(input logic [31:0] x);
                logic [31:0] s;
                s = x;
                s = s ^ (s << 13);
                s = s ^ (s >> 17);
                s = s ^ (s << 5);
                return s;
        endfunction

        // Class from bits 27:24.
        function automatic instr_class_t class_of(input logic [3:0] op);
                if (op[3:2] == 2'b00)
                begin
                        return CLS_DATA_PROC;
                end
                else if (op[3:2] == 2'b01)
                begin
                        return CLS_LOAD_STORE;
                end
                else if (op[3:1] == 3'b101)
                begin
                        return CLS_BRANCH;
                end
                else if (op == 4'hF)
                begin
                        return CLS_SWI;
                end
                return CLS_UNDEF;
        endfunction

        function automatic exp_entry_t make_entry(input logic [`DEC_INSTR_W-1:0] instr,
                                                  input logic irq, input logic fiq);
                exp_entry_t e;
                e.instr = instr;
                e.cls   = class_of(instr[27:24]);
                e.cond  = instr[31:28];
                e.rn    = instr[19:16];
                e.rd    = instr[15:12];
                e.irq   = irq;
                e.fiq   = fiq;
                return e;
        endfunction

        task automatic stop_on_failure(input string why);
                $display("%s", why);
                $display("Simulation FAILED");
                $fatal(1, "Run stopped at the first failure.");
        endtask

        task automatic check_value(input string name, input logic [63:0] actual,
                                   input logic [63:0] expected);
                if (actual !== expected)
                begin
                        error_count++;
                        $display("** Error: %s is 0x%0h, expected 0x%0h at time %0t",
                                 name, actual, expected, $time);
                        stop_on_failure("Output does not match the model.");
                end
        endtask

        task automatic compare_output(input exp_entry_t e);
                check_value("o_instruction", o_instruction, e.instr);
                check_value("o_class", o_class, e.cls);
                check_value("o_cond", o_cond, e.cond);
                check_value("o_rd", o_rd, e.rd);
                check_value("o_rn", o_rn, e.rn);
                check_value("o_irq", o_irq, e.irq);
                check_value("o_fiq", o_fiq, e.fiq);
                checked_count++;
        endtask

        // Accepted word goes into the queue, split in two if it is a BL.
        task automatic model_accept();
                logic [`DEC_INSTR_W-1:0] link_word;
                logic [`DEC_INSTR_W-1:0] branch_word;
                if (i_instruction[27:25] == 3'b101 && i_instruction[24])
                begin
                        // Link write keeps flags and condition.
                        link_word        = i_instruction;
                        link_word[27:0]  = i_cpsr[`DEC_CPSR_T] ? `DEC_LINK_THUMB : `DEC_LINK_ARM;
                        branch_word      = i_instruction;
                        branch_word[`DEC_BL_BIT] = 1'b0;
                        // Interrupts masked on both halves.
                        exp_q.push_back(make_entry(link_word, 1'b0, 1'b0));
                        exp_q.push_back(make_entry(branch_word, 1'b0, 1'b0));
                        bl_pending = 1'b1;
                end
                else
                begin
                        exp_q.push_back(make_entry(i_instruction, i_irq, i_fiq));
                end
        endtask

        // New random inputs for the next edge.
        task automatic drive_random();
                logic [31:0]                    r_ctl;
                logic [31:0]                    r_word;
                logic [31:0]                    r_cpsr;
                logic [`DEC_INSTR_W-1:0]        instr;
                rng_state = xorshift32(rng_state);
                r_ctl     = rng_state;
                rng_state = xorshift32(rng_state);
                r_word    = rng_state;
                rng_state = xorshift32(rng_state);
                r_cpsr    = rng_state;
                instr = {r_ctl[31:29], r_word};
                // About one in four is a BL.
                if (r_ctl[1:0] == 2'b00)
                begin
                        instr[27:24] = 4'b1011;
                end
                // T bit frozen while a link half is still to come.
                if (bl_pending)
                begin
                        r_cpsr[`DEC_CPSR_T] = i_cpsr[`DEC_CPSR_T];
                end
                i_instruction       <= instr;
                i_instruction_valid <= (r_ctl[3:2] != 2'b00);
                i_stall_from_issue  <= (r_ctl[5:4] == 2'b00);
                i_irq               <= r_ctl[6];
                i_fiq               <= r_ctl[7];
                // Rare flush.
                i_clear             <= (r_ctl[13:8] == 6'd0);
                i_cpsr              <= r_cpsr;
        endtask

        task automatic drive_quiet();
                i_instruction_valid <= 1'b0;
                i_stall_from_issue  <= 1'b0;
                i_clear             <= 1'b0;
        endtask

        // Checker and model run on the falling edge where all signals are settled.
        always @(negedge i_clk)
        begin
                if (!i_reset)
                begin
                        check_value("o_stall_to_fetch", o_stall_to_fetch,
                                    i_stall_from_issue | bl_pending);
                        // Nothing comes out before the first acceptance.
                        if (!seen_accept)
                        begin
                                check_value("o_valid", o_valid, 1'b0);
                        end
                        if (o_valid && exp_q.size() == 0)
                        begin
                                stop_on_failure("o_valid is high but no output was expected.");
                        end
                        else if (o_valid && !i_stall_from_issue)
                        begin
                                compare_output(exp_q.pop_front());
                                idle_cycles = 0;
                        end
                        else if (exp_q.size() != 0)
                        begin
                                idle_cycles++;
                                if (idle_cycles > IDLE_LIMIT)
                                begin
                                        stop_on_failure("Timeout: no output while entries wait.");
                                end
                        end
                        // What the coming edge does.
                        if (i_clear)
                        begin
                                exp_q.delete();
                                bl_pending  = 1'b0;
                                idle_cycles = 0;
                        end
                        else
                        begin
                                // Link half taken by the output stage.
                                if (bl_pending && !i_stall_from_issue)
                                begin
                                        bl_pending = 1'b0;
                                end
                                if (i_instruction_valid && !o_stall_to_fetch)
                                begin
                                        model_accept();
                                        seen_accept = 1'b1;
                                end
                        end
                end
        end

        initial
        begin
                rng_state           = 32'h3542726c;
                i_clk               = 1'b0;
                i_reset             = 1'b1;
                i_instruction       = '0;
                i_instruction_valid = 1'b0;
                i_irq               = 1'b0;
                i_fiq               = 1'b0;
                i_cpsr              = '0;
                i_clear             = 1'b0;
                i_stall_from_issue  = 1'b0;
                bl_pending          = 1'b0;
                seen_accept         = 1'b0;
                error_count         = 0;
                idle_cycles         = 0;
                checked_count       = 0;
                // Two cycles of reset.
                repeat (2)
                begin
                        @(posedge i_clk);
                end
                i_reset <= 1'b0;
                repeat (RUN_CYCLES)
                begin
                        drive_random();
                        @(posedge i_clk);
                end
                // Let the pipeline empty.
                drive_quiet();
                drain_cycles = 0;
                while (exp_q.size() != 0 && drain_cycles < DRAIN_LIMIT)
                begin
                        @(posedge i_clk);
                        drain_cycles++;
                end
                if (exp_q.size() != 0)
                begin
                        stop_on_failure("Timeout: expected outputs never left the DUT.");
                end
                // Stray outputs would show up here.
                repeat (4)
                begin
                        @(posedge i_clk);
                end
                if (error_count == 0 && exp_q.size() == 0)
                begin
                        $display("%0d outputs checked", checked_count);
                        $display("Simulation PASSED");
                        $finish;
                end
                else
                begin
                        stop_on_failure("Checks failed during the run.");
                end
        end

endmodule

// ==== build.f ====
+incdir+common
common/decode_pkg.sv
common/instr_if.sv
src/fetch_latch.sv
bl_expand/bl_expand_fsm.sv
src/decode_output_stage.sv
src/decode_front.sv
testbench/tb_decode_front.sv
